/* all.f */
+incdir+source
source/nes_bus_pkg.sv
source/nes_bus_if.sv
source/cpu_memory_map.sv
source/bus_ram.sv
source/ppu_regs.sv
source/controller_port.sv
source/dma_counter.sv
source/dma_sequencer.sv
source/nes_cpu_bus_top.sv
verif/tb_nes_cpu_bus.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_nes_cpu_bus
RTL_TOP   ?= nes_cpu_bus_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "^$(PASS_STR)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_nes_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nes_bus_params.svh"

module tb_nes_cpu_bus;
    import nes_bus_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_ACC      = 16;
    localparam logic [15:0] OAMADDR_REG = `PPU_BASE + 16'(`PPU_OAMADDR);
    localparam logic [15:0] OAMDATA_REG = `PPU_BASE + 16'(`PPU_OAMDATA);
    // cycles of all tests, dma allowed twice its length for enable gaps
    localparam int TEST_CYCLES = 3 + 8 * N_ACC + 40 + 13 + 256 + 2 * `DMA_CYCLES
                               + 2 * 256 + 3 * N_ACC + 20;
    localparam int WATCHDOG_NS = 4 * TEST_CYCLES * CLK_PERIOD;

    logic                   clk;
    logic                   i_rst;
    logic                   i_clk_en;
    logic [15:0]            i_address_cpu;
    logic                   i_rw_cpu;
    byte_t                  i_data_cpu;
    byte_t                  o_data_cpu;
    logic                   o_rdy;
    byte_t                  i_buttons;
    logic                   i_prg_we;
    logic [`PRG_ADDR_W-1:0] i_prg_addr;
    byte_t                  i_prg_data;

    // reference byte models
    byte_t ram_model [2**`RAM_ADDR_W];
    byte_t prg_model [2**`PRG_ADDR_W];
    byte_t oam_model [256];
    byte_t latch_model [8];

    int errors;
    int tests_run;
    int tests_failed;

    nes_cpu_bus_top dut (
        .i_clk         (clk),
        .i_rst         (i_rst),
        .i_clk_en      (i_clk_en),
        .i_address_cpu (i_address_cpu),
        .i_rw_cpu      (i_rw_cpu),
        .i_data_cpu    (i_data_cpu),
        .o_data_cpu    (o_data_cpu),
        .o_rdy         (o_rdy),
        .i_buttons     (i_buttons),
        .i_prg_we      (i_prg_we),
        .i_prg_addr    (i_prg_addr),
        .i_prg_data    (i_prg_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic byte_t rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    task automatic report_mismatch(input string what, input byte_t got, input byte_t exp);
        $display("[FAIL] %0t: %s, got 0x%02h expected 0x%02h", $time, what, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            $display("%s: failed with %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    // one cpu cycle, read data sampled well before the rising edge
    task automatic drive_bus(input logic [15:0] addr, input logic rw, input byte_t data,
                             input logic en, output byte_t rdata);
        @(negedge clk);
        i_prg_we      = 1'b0;
        i_clk_en      = en;
        i_address_cpu = addr;
        i_rw_cpu      = rw;
        i_data_cpu    = data;
        #1;
        rdata = o_data_cpu;
    endtask

    task automatic write_cpu(input logic [15:0] addr, input byte_t data);
        byte_t unused;
        drive_bus(addr, `RW_WRITE, data, 1'b1, unused);
    endtask

    task automatic read_cpu(input logic [15:0] addr, output byte_t rdata);
        drive_bus(addr, `RW_READ, 8'h00, 1'b1, rdata);
    endtask

    task automatic idle_bus();
        @(negedge clk);
        i_prg_we = 1'b0;
        i_clk_en = 1'b0;
    endtask

    task automatic program_memory_readback();
        int                     errs0;
        logic [`PRG_ADDR_W-1:0] offs [N_ACC];
        logic [31:0]            r;
        byte_t                  rd;
        errs0 = errors;
        for (int i = 0; i < N_ACC; i++)
        begin
            r = $urandom;
            offs[i] = r[`PRG_ADDR_W-1:0];
            @(negedge clk);
            i_clk_en   = 1'b0;
            i_prg_we   = 1'b1;
            i_prg_addr = offs[i];
            i_prg_data = r[31:24];
            prg_model[offs[i]] = r[31:24];
        end
        for (int i = 0; i < N_ACC; i++)
        begin
            read_cpu(`PRG_BASE + {1'b0, offs[i]}, rd);
            if (rd !== prg_model[offs[i]])
                report_mismatch("program memory read", rd, prg_model[offs[i]]);
        end
        write_cpu(`PRG_BASE + {1'b0, offs[0]}, ~prg_model[offs[0]]);   // must be dropped
        read_cpu(`PRG_BASE + {1'b0, offs[0]}, rd);
        if (rd !== prg_model[offs[0]])
            report_mismatch("program memory after cpu write", rd, prg_model[offs[0]]);
        idle_bus();
        finish_test("program memory", errs0);
    endtask

    task automatic work_ram_mirroring();
        int                     errs0;
        logic [`RAM_ADDR_W-1:0] addrs [N_ACC];
        logic [31:0]            r;
        byte_t                  rd;
        errs0 = errors;
        for (int i = 0; i < N_ACC; i++)
        begin
            r = $urandom;
            addrs[i] = r[`RAM_ADDR_W-1:0];
            ram_model[addrs[i]] = r[31:24];
            write_cpu({5'b0, addrs[i]}, r[31:24]);
        end
        for (int i = 0; i < N_ACC; i++)
        begin
            for (int m = 1; m < 4; m++)
            begin
                read_cpu({3'b000, 2'(m), addrs[i]}, rd);
                if (rd !== ram_model[addrs[i]])
                    report_mismatch("work ram mirror read", rd, ram_model[addrs[i]]);
            end
        end
        // no commit without clock enable
        drive_bus({5'b0, addrs[0]}, `RW_WRITE, ~ram_model[addrs[0]], 1'b0, rd);
        read_cpu({5'b0, addrs[0]}, rd);
        if (rd !== ram_model[addrs[0]])
            report_mismatch("work ram write with clock enable low", rd, ram_model[addrs[0]]);
        idle_bus();
        finish_test("work ram mirroring", errs0);
    endtask

    task automatic ppu_register_access();
        int          errs0;
        logic [31:0] r;
        byte_t       rd;
        byte_t       start;
        errs0 = errors;
        for (int rs = 0; rs < 8; rs++)
        begin
            if (rs == 3 || rs == 4)
                continue;
            r = $urandom;
            latch_model[rs] = r[7:0];
            write_cpu({3'b001, r[17:8], 3'(rs)}, r[7:0]);
            read_cpu({3'b001, r[27:18], 3'(rs)}, rd);    // other mirror
            if (rd !== latch_model[rs])
                report_mismatch("ppu register mirror", rd, latch_model[rs]);
        end
        start = rand_byte();
        write_cpu(OAMADDR_REG, start);
        for (int i = 0; i < 8; i++)
        begin
            oam_model[start + 8'(i)] = rand_byte();
            write_cpu(OAMDATA_REG, oam_model[start + 8'(i)]);
        end
        write_cpu(OAMADDR_REG, start);
        for (int i = 0; i < 2; i++)
        begin
            read_cpu(OAMDATA_REG, rd);    // same byte twice
            if (rd !== oam_model[start])
                report_mismatch("oam read without increment", rd, oam_model[start]);
        end
        for (int i = 1; i < 8; i++)
        begin
            write_cpu(OAMADDR_REG, start + 8'(i));
            read_cpu(OAMDATA_REG, rd);
            if (rd !== oam_model[start + 8'(i)])
                report_mismatch("oam data readback", rd, oam_model[start + 8'(i)]);
        end
        idle_bus();
        finish_test("ppu registers", errs0);
    endtask

    task automatic controller_serial_read();
        int    errs0;
        byte_t btn;
        byte_t exp;
        byte_t rd;
        errs0 = errors;
        btn = rand_byte();
        idle_bus();
        i_buttons = btn;
        write_cpu(`CTRL_REG, 8'h01);
        write_cpu(`CTRL_REG, 8'h00);
        for (int i = 0; i < 9; i++)
        begin
            exp = (i < 8) ? {7'b0, btn[i]} : 8'h01;   // A first, then ones
            read_cpu(`CTRL_REG, rd);
            if (rd !== exp)
                report_mismatch("controller serial bit", rd, exp);
        end
        idle_bus();
        finish_test("controller port", errs0);
    endtask

    task automatic sprite_dma_copy();
        int          errs0;
        int          n_en;
        int          n_cyc;
        logic [31:0] r;
        logic        en;
        byte_t       page;
        byte_t       rd;
        errs0 = errors;
        r = $urandom;
        page = {3'b000, r[4:0]};    // work ram or one of its mirrors
        for (int i = 0; i < 256; i++)
        begin
            r = $urandom;
            ram_model[{page[2:0], 8'(i)}] = r[7:0];
            write_cpu({page, 8'(i)}, r[7:0]);
        end
        write_cpu(OAMADDR_REG, 8'h00);
        write_cpu(`DMA_REG, page);
        n_en = 0;
        n_cyc = 0;
        while (n_en < `DMA_CYCLES && n_cyc < 4 * `DMA_CYCLES)
        begin
            r = $urandom;
            en = (r[1:0] != 2'b00);
            // cpu keeps hitting the same page, reads and writes alike
            drive_bus({page, r[15:8]}, r[16], r[31:24], en, rd);
            if (o_rdy !== 1'b0)
            begin
                report_mismatch("o_rdy while dma runs", {7'b0, o_rdy}, 8'h00);
                break;
            end
            if (rd !== 8'h00)
                report_mismatch("cpu read data while dma runs", rd, 8'h00);
            if (en)
                n_en++;
            n_cyc++;
        end
        if (n_cyc >= 4 * `DMA_CYCLES)
        begin
            $display("sprite DMA still running after %0d cycles", n_cyc);
            errors++;
        end
        drive_bus(OAMADDR_REG, `RW_WRITE, 8'h00, 1'b1, rd);
        if (o_rdy !== 1'b1)
            report_mismatch("o_rdy after dma", {7'b0, o_rdy}, 8'h01);
        for (int i = 0; i < 256; i++)
        begin
            oam_model[i] = ram_model[{page[2:0], 8'(i)}];
            write_cpu(OAMADDR_REG, 8'(i));
            read_cpu(OAMDATA_REG, rd);
            if (rd !== oam_model[i])
                report_mismatch("oam byte after dma", rd, oam_model[i]);
        end
        idle_bus();
        finish_test("sprite dma", errs0);
    endtask

    task automatic unmapped_reads_zero();
        int          errs0;
        logic [15:0] addr;
        logic [31:0] r;
        byte_t       rd;
        errs0 = errors;
        for (int i = 0; i < N_ACC; i++)
        begin
            r = $urandom;
            addr = {2'b01, r[13:0]};
            if (addr == `CTRL_REG || addr == `DMA_REG)
                addr = 16'h4015;
            read_cpu(addr, rd);
            if (rd !== 8'h00)
                report_mismatch("unmapped read", rd, 8'h00);
            ram_model[r[26:16]] = r[31:24];
            drive_bus({5'b0, r[26:16]}, `RW_WRITE, r[31:24], 1'b1, rd);
            if (rd !== 8'h00)
                report_mismatch("read data during write", rd, 8'h00);
            drive_bus({5'b0, r[26:16]}, `RW_READ, 8'h00, 1'b0, rd);
            if (rd !== 8'h00)
                report_mismatch("read data with clock enable low", rd, 8'h00);
        end
        idle_bus();
        finish_test("unmapped reads", errs0);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(23));
        $timeformat(-9, 0, " ns", 0);
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        i_rst         = 1'b1;
        i_clk_en      = 1'b0;
        i_address_cpu = 16'h0000;
        i_rw_cpu      = `RW_READ;
        i_data_cpu    = 8'h00;
        i_buttons     = 8'h00;
        i_prg_we      = 1'b0;
        i_prg_addr    = '0;
        i_prg_data    = 8'h00;
        for (int i = 0; i < 8; i++)
            latch_model[i] = 8'h00;
        repeat (3) @(negedge clk);
        i_rst = 1'b0;
        #1;
        if (o_rdy !== 1'b1)
            report_mismatch("o_rdy after reset", {7'b0, o_rdy}, 8'h01);

        program_memory_readback();
        work_ram_mirroring();
        ppu_register_access();
        controller_serial_read();
        sprite_dma_copy();
        unmapped_reads_zero();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* source/nes_cpu_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nes_bus_params.svh"

module nes_cpu_bus_top (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_clk_en,

    input  logic [15:0]             i_address_cpu,
    input  logic                    i_rw_cpu,
    input  nes_bus_pkg::byte_t      i_data_cpu,
    output nes_bus_pkg::byte_t      o_data_cpu,
    output logic                    o_rdy,       // low while sprite dma runs

    input  nes_bus_pkg::byte_t      i_buttons,

    // program memory loader
    input  logic                    i_prg_we,
    input  logic [`PRG_ADDR_W-1:0]  i_prg_addr,
    input  nes_bus_pkg::byte_t      i_prg_data
);
    import nes_bus_pkg::*;

    bus_req_t cpu_req;
    bus_req_t dma_req;
    logic     dma_active;
    logic     dma_start;
    byte_t    dma_page;
    byte_t    map_data;
    logic     ctrl_load;
    logic     ctrl_shift;
    logic     ctrl_bit;

    mem_port_if #(.ADDR_W(`RAM_ADDR_W)) ram_if ();
    mem_port_if #(.ADDR_W(`PRG_ADDR_W)) prg_if ();
    ppu_port_if                         ppu_if ();

    assign cpu_req.addr  = i_address_cpu;
    assign cpu_req.rw    = i_rw_cpu;
    assign cpu_req.wdata = i_data_cpu;
    assign cpu_req.en    = 1'b1;    // cpu always presents an access

    // loader owns the write side of program memory
    assign prg_if.we    = i_prg_we;
    assign prg_if.waddr = i_prg_addr;
    assign prg_if.wdata = i_prg_data;

    cpu_memory_map u_map (
        .i_clk_en     (i_clk_en),
        .i_cpu_req    (cpu_req),
        .i_dma_req    (dma_req),
        .i_dma_active (dma_active),
        .o_data       (map_data),
        .ram          (ram_if.master),
        .prg          (prg_if.master),
        .ppu          (ppu_if.master),
        .o_ctrl_load  (ctrl_load),
        .o_ctrl_shift (ctrl_shift),
        .i_ctrl_bit   (ctrl_bit),
        .o_dma_start  (dma_start),
        .o_dma_page   (dma_page)
    );

    bus_ram #(.ADDR_W(`RAM_ADDR_W)) u_wram (.i_clk(i_clk), .port(ram_if.mem));
    bus_ram #(.ADDR_W(`PRG_ADDR_W)) u_prg  (.i_clk(i_clk), .port(prg_if.mem));

    ppu_regs u_ppu (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_clk_en (i_clk_en),
        .bus      (ppu_if.slave)
    );

    controller_port u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_buttons    (i_buttons),
        .i_load       (ctrl_load),
        .i_load_level (cpu_req.wdata[0]),
        .i_shift      (ctrl_shift),
        .o_bit        (ctrl_bit)
    );

    dma_sequencer u_dma (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_clk_en (i_clk_en),
        .i_start  (dma_start),
        .i_page   (dma_page),
        .i_rdata  (map_data),
        .o_req    (dma_req),
        .o_active (dma_active)
    );

    // cpu sees nothing while dma holds the bus
    assign o_data_cpu = dma_active ? '0 : map_data;
    assign o_rdy      = ~dma_active;

endmodule

`default_nettype wire

/* source/dma_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nes_bus_params.svh"

// sprite dma, copies one page into oam through register 4
module dma_sequencer (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_clk_en,
    input  logic                  i_start,
    input  nes_bus_pkg::byte_t    i_page,
    input  nes_bus_pkg::byte_t    i_rdata,
    output nes_bus_pkg::bus_req_t o_req,
    output logic                  o_active
);
    import nes_bus_pkg::*;

    localparam logic [15:0] OAM_DATA_ADDR = `PPU_BASE + 16'(`PPU_OAMDATA);

    dma_state_t state;
    byte_t      page;
    byte_t      data_q;     // byte in flight
    byte_t      index;
    logic       phase;
    logic       last;
    logic       start_copy;
    logic       step;

    assign start_copy = (state == DMA_IDLE) && i_start;
    assign step       = (state == DMA_COPY) && i_clk_en;
    assign o_active   = (state == DMA_COPY);

    dma_counter u_counter (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_clear (start_copy),
        .i_step  (step),
        .o_phase (phase),
        .o_index (index),
        .o_last  (last)
    );

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            state <= DMA_IDLE;
        else if (start_copy)
            state <= DMA_COPY;
        else if (step && last)
            state <= DMA_IDLE;
    end

    always_ff @(posedge i_clk)
    begin
        if (start_copy)
            page <= i_page;
        if (step && !phase)
            data_q <= i_rdata;    // read half of the pair
    end

    // even cycles read {page, index}, odd cycles write oam data
    assign o_req.addr  = phase ? OAM_DATA_ADDR : {page, index};
    assign o_req.rw    = phase ? `RW_WRITE : `RW_READ;
    assign o_req.wdata = data_q;
    assign o_req.en    = o_active;

endmodule

`default_nettype wire

/* source/dma_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nes_bus_params.svh"

module dma_counter (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_clear,
    input  logic               i_step,
    output logic               o_phase,   // 1 on write cycles
    output nes_bus_pkg::byte_t o_index,
    output logic               o_last
);
    localparam int CNT_W = $clog2(`DMA_CYCLES);

    logic [CNT_W-1:0] count;

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_clear)
            count <= '0;
        else if (i_step)
            count <= count + 1'b1;    // rolls back to 0 after the last cycle
    end

    assign o_phase = count[0];
    assign o_index = count[CNT_W-1:1];
    assign o_last  = (count == CNT_W'(`DMA_CYCLES - 1));

endmodule

`default_nettype wire

/* source/controller_port.sv */
`timescale 1ns/1ps
`default_nettype none

// serial game pad, A comes out first
module controller_port (
    input  logic               i_clk,
    input  logic               i_rst,
    input  nes_bus_pkg::byte_t i_buttons,     // active high, A in bit 0
    input  logic               i_load,
    input  logic               i_load_level,
    input  logic               i_shift,
    output logic               o_bit
);
    import nes_bus_pkg::*;

    byte_t sh;
    logic  level_q;
    logic  level;

    // level written this cycle wins over the stored one
    assign level = i_load ? i_load_level : level_q;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            sh      <= '0;
            level_q <= 1'b0;
        end
        else
        begin
            if (i_load)
                level_q <= i_load_level;

            if (level)
                sh <= i_buttons;          // follow the pad while latching
            else if (i_shift)
                sh <= {1'b1, sh[7:1]};    // ones after the last button
        end
    end

    assign o_bit = sh[0];

endmodule

`default_nettype wire

/* source/ppu_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nes_bus_params.svh"

module ppu_regs (
    input logic       i_clk,
    input logic       i_rst,
    input logic       i_clk_en,
    ppu_port_if.slave bus
);
    import nes_bus_pkg::*;

    logic                   wr;
    logic [`OAM_ADDR_W-1:0] oam_addr;
    byte_t                  latch [8];   // stand-ins for the rendering registers

    mem_port_if #(.ADDR_W(`OAM_ADDR_W)) oam_if ();

    bus_ram #(.ADDR_W(`OAM_ADDR_W)) u_oam (
        .i_clk (i_clk),
        .port  (oam_if.mem)
    );

    assign wr = i_clk_en && bus.sel && (bus.rw == `RW_WRITE);

    // oam is read and written at the current oam address
    assign oam_if.raddr = oam_addr;
    assign oam_if.waddr = oam_addr;
    assign oam_if.wdata = bus.wdata;
    assign oam_if.we    = wr && (bus.rs == `PPU_OAMDATA);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            oam_addr <= '0;
            latch    <= '{default: '0};
        end
        else if (wr)
        begin
            if (bus.rs == `PPU_OAMADDR)
                oam_addr <= bus.wdata;
            else if (bus.rs == `PPU_OAMDATA)
                oam_addr <= oam_addr + 1'b1;    // wraps at 256
            else
                latch[bus.rs] <= bus.wdata;
        end
    end

    always_comb
    begin
        case (bus.rs)
            `PPU_OAMADDR: bus.rdata = oam_addr;
            `PPU_OAMDATA: bus.rdata = oam_if.rdata;   // no increment on read
            default:      bus.rdata = latch[bus.rs];
        endcase
    end

endmodule

`default_nettype wire

/* source/bus_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// byte array, synchronous write and combinational read
module bus_ram #(
    parameter int ADDR_W = 8
) (
    input logic     i_clk,
    mem_port_if.mem port
);
    import nes_bus_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    byte_t mem [DEPTH];

    always_ff @(posedge i_clk)
    begin
        if (port.we)
        begin
            mem[port.waddr] <= port.wdata;
        end
    end

    assign port.rdata = mem[port.raddr];

endmodule

`default_nettype wire

/* source/cpu_memory_map.sv */
`timescale 1ns/1ps
`default_nettype none
`include "nes_bus_params.svh"

module cpu_memory_map (
    input  logic                  i_clk_en,
    input  nes_bus_pkg::bus_req_t i_cpu_req,
    input  nes_bus_pkg::bus_req_t i_dma_req,
    input  logic                  i_dma_active,
    output nes_bus_pkg::byte_t    o_data,        // read data of selected request

    mem_port_if.master            ram,
    mem_port_if.master            prg,           // read side only
    ppu_port_if.master            ppu,

    output logic                  o_ctrl_load,
    output logic                  o_ctrl_shift,
    input  logic                  i_ctrl_bit,

    output logic                  o_dma_start,
    output nes_bus_pkg::byte_t    o_dma_page
);
    import nes_bus_pkg::*;

    bus_req_t    req;
    logic        acc;
    logic        is_rd;
    logic        in_ram;
    logic        in_ppu;
    logic        in_dma;
    logic        in_ctrl;
    logic        in_prg;
    logic [15:0] prg_off;

    // dma owns the bus while it runs
    assign req   = i_dma_active ? i_dma_req : i_cpu_req;
    assign acc   = i_clk_en && req.en;
    assign is_rd = (req.rw == `RW_READ);

    // address windows
    assign in_ram  = (req.addr < `PPU_BASE);
    assign in_ppu  = (req.addr >= `PPU_BASE) && (req.addr < `PPU_END);
    assign in_dma  = (req.addr == `DMA_REG);
    assign in_ctrl = (req.addr == `CTRL_REG);
    assign in_prg  = (req.addr >= `PRG_BASE);

    // work ram, low bits only so the four mirrors land on the same byte
    assign ram.raddr = req.addr[`RAM_ADDR_W-1:0];
    assign ram.waddr = req.addr[`RAM_ADDR_W-1:0];
    assign ram.wdata = req.wdata;
    assign ram.we    = acc && in_ram && !is_rd;

    // program memory is read only from here
    assign prg_off   = req.addr - `PRG_BASE;
    assign prg.raddr = prg_off[`PRG_ADDR_W-1:0];

    // picture unit registers repeat every 8 bytes
    assign ppu.sel   = acc && in_ppu;
    assign ppu.rs    = req.addr[2:0];
    assign ppu.rw    = req.rw;
    assign ppu.wdata = req.wdata;

    assign o_ctrl_load  = acc && in_ctrl && !is_rd;
    assign o_ctrl_shift = acc && in_ctrl && is_rd;    // shift on the edge ending the read

    assign o_dma_start = acc && in_dma && !is_rd;
    assign o_dma_page  = req.wdata;

    // read data mux, unmapped reads give 0
    always_comb
    begin
        o_data = '0;
        if (acc && is_rd)
        begin
            if (in_ram)
            begin
                o_data = ram.rdata;
            end
            else if (in_ppu)
            begin
                o_data = ppu.rdata;
            end
            else if (in_ctrl)
            begin
                o_data = {7'b0, i_ctrl_bit};  // serial bit on d0
            end
            else if (in_prg)
            begin
                o_data = prg.rdata;
            end
        end
    end

endmodule

`default_nettype wire

/* source/nes_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// byte memory port, read side combinational
interface mem_port_if #(
    parameter int ADDR_W = 11
);
    import nes_bus_pkg::*;

    logic [ADDR_W-1:0] raddr;
    byte_t             rdata;
    logic              we;
    logic [ADDR_W-1:0] waddr;
    byte_t             wdata;

    modport master (output raddr, input rdata, output we, output waddr, output wdata);
    modport mem    (input raddr, output rdata, input we, input waddr, input wdata);

endinterface

// picture unit register access
interface ppu_port_if;
    import nes_bus_pkg::*;

    logic       sel;    // already qualified by clock enable
    logic [2:0] rs;     // register number
    logic       rw;
    byte_t      wdata;
    byte_t      rdata;

    modport master (output sel, output rs, output rw, output wdata, input rdata);
    modport slave  (input sel, input rs, input rw, input wdata, output rdata);

endinterface

`default_nettype wire

/* source/nes_bus_pkg.sv */
`default_nettype none

// shared types for the cpu side bus
package nes_bus_pkg;

    // one data byte on the cpu bus
    typedef logic [7:0] byte_t;

    // single bus access as seen by the memory map
    typedef struct packed {
        logic [15:0] addr;
        logic        rw;    // 1 = read, 0 = write
        byte_t       wdata;
        logic        en;    // request present
    } bus_req_t;

    // sprite dma sequencer states
    typedef enum logic {
        DMA_IDLE = 1'b0,
        DMA_COPY = 1'b1
    } dma_state_t;

endpackage

`default_nettype wire

/* source/nes_bus_params.svh */
`ifndef NES_BUS_PARAMS_SVH
`define NES_BUS_PARAMS_SVH

// rw encodings of the cpu bus
`define RW_READ     1'b1
`define RW_WRITE    1'b0

// memory sizes as address widths
`define RAM_ADDR_W  11          // 2 KB work ram, mirrored below 0x2000
`define PRG_ADDR_W  15          // 32 KB program memory
`define OAM_ADDR_W  8           // 256 byte sprite memory

// address windows
`define PPU_BASE    16'h2000
`define PPU_END     16'h4000
`define DMA_REG     16'h4014
`define CTRL_REG    16'h4016
`define PRG_BASE    16'h8000

`define PPU_OAMADDR 3'd3
`define PPU_OAMDATA 3'd4
`define DMA_CYCLES  512         // one read and one write per byte

`endif
